// File: hdl/rs_settings.svh
// reservation station sizing
`ifndef RS_SETTINGS_SVH
`define RS_SETTINGS_SVH

// entries held in the station
`define RS_DEPTH 16

// dispatch, issue and cdb ways
`define RS_WAYS 3

// operand width, value or tag
`define RS_XLEN 32

// physical registers, gives a 6 bit tag
`define RS_PRF 64

// reorder buffer entries, gives a 4 bit index
`define RS_ROB 16

`endif

// File: hdl/rs_pkg.sv
// reservation station types
`include "rs_settings.svh"

package rs_pkg;

    typedef logic [$clog2(`RS_PRF)-1:0] prf_tag_t;
    typedef logic [$clog2(`RS_ROB)-1:0] rob_idx_t;

    // value when ready, tag in the low bits when not
    typedef logic [`RS_XLEN-1:0] operand_t;

    // operation class, replaces separate mem read/write flags
    typedef enum logic [1:0] {
        op_alu,
        op_load,
        op_store
    } rs_op_e;

    // one instruction as it sits in an entry
    typedef struct packed {
        operand_t opa;
        operand_t opb;
        logic     opa_ready;
        logic     opb_ready;
        prf_tag_t dest;
        rob_idx_t rob;
        rs_op_e   op;
    } rs_slot_t;

    // capture cdb data for any waiting operand whose tag is broadcast
    function automatic rs_slot_t slot_wakeup(
        input rs_slot_t                   slot,
        input logic [`RS_WAYS-1:0]        cdb_valid,
        input prf_tag_t [`RS_WAYS-1:0]    cdb_tag,
        input operand_t [`RS_WAYS-1:0]    cdb_data
    );
        rs_slot_t woken;
        woken = slot;
        for (int j = 0; j < `RS_WAYS; j++) begin
            if (!slot.opa_ready && cdb_valid[j] &&
                cdb_tag[j] == slot.opa[$bits(prf_tag_t)-1:0]) begin
                woken.opa       = cdb_data[j];
                woken.opa_ready = 1'b1;
            end
            if (!slot.opb_ready && cdb_valid[j] &&
                cdb_tag[j] == slot.opb[$bits(prf_tag_t)-1:0]) begin
                woken.opb       = cdb_data[j];
                woken.opb_ready = 1'b1;
            end
        end
        return woken;
    endfunction

endpackage

// File: hdl/rs_bank_if.sv
// entry bank interface
`timescale 1ns/1ps
`include "rs_settings.svh"

interface rs_bank_if
    import rs_pkg::*;
();

    // one load strobe and slot per entry, from dispatch
    logic [`RS_DEPTH-1:0]     alloc;
    rs_slot_t [`RS_DEPTH-1:0] alloc_slot;

    // entries leaving on an issue transfer
    logic [`RS_DEPTH-1:0]     grant;

    // entry state back out of the store
    logic [`RS_DEPTH-1:0]     free;
    // occupied with both operands present
    logic [`RS_DEPTH-1:0]     ready;
    rs_slot_t [`RS_DEPTH-1:0] held;

    modport store (
        input  alloc,
        input  alloc_slot,
        input  grant,
        output free,
        output ready,
        output held
    );

    modport dispatch (
        output alloc,
        output alloc_slot,
        input  free
    );

    modport issue (
        output grant,
        input  ready,
        input  held
    );

endinterface

// File: hdl/rs_priority_pick.sv
// lowest index multi pick
`timescale 1ns/1ps
`include "rs_settings.svh"

module rs_priority_pick #(
    parameter int entries = `RS_DEPTH,
    parameter int picks   = `RS_WAYS
) (
    input  logic [entries-1:0]             request,
    // upper bound on picks this cycle
    input  logic [$clog2(picks+1)-1:0]     count,
    // one-hot entry vector per pick slot, zero when unused
    output logic [picks-1:0][entries-1:0]  pick,
    output logic [$clog2(picks+1)-1:0]     picked
);

    localparam int cnt_w = $clog2(picks + 1);

    // walk from entry 0, first requests win
    always_comb begin
        pick   = '0;
        picked = '0;
        for (int i = 0; i < entries; i++) begin
            // picked stays below count, so below picks
            if (request[i] && picked < count) begin
                pick[picked][i] = 1'b1;
                picked          = picked + cnt_w'(1);
            end
        end
    end

endmodule

// File: hdl/rs_dispatch_route.sv
// dispatch handshake and allocation
`timescale 1ns/1ps
`include "rs_settings.svh"

module rs_dispatch_route
    import rs_pkg::*;
(
    input  logic [`RS_WAYS-1:0]         dispatch_valid,
    input  operand_t [`RS_WAYS-1:0]     dispatch_opa,
    input  operand_t [`RS_WAYS-1:0]     dispatch_opb,
    input  logic [`RS_WAYS-1:0]         dispatch_opa_ready,
    input  logic [`RS_WAYS-1:0]         dispatch_opb_ready,
    input  prf_tag_t [`RS_WAYS-1:0]     dispatch_dest,
    input  rob_idx_t [`RS_WAYS-1:0]     dispatch_rob,
    input  rs_op_e [`RS_WAYS-1:0]       dispatch_op,

    input  logic [`RS_WAYS-1:0]         cdb_valid,
    input  prf_tag_t [`RS_WAYS-1:0]     cdb_tag,
    input  operand_t [`RS_WAYS-1:0]     cdb_data,

    output logic                        dispatch_ready,
    output logic [$clog2(`RS_DEPTH):0]  free_count,

    rs_bank_if.dispatch                 bank
);

    localparam int way_cw = $clog2(`RS_WAYS + 1);
    localparam int cnt_w  = $clog2(`RS_DEPTH) + 1;

    rs_slot_t [`RS_WAYS-1:0]            raw_slot;
    // after same cycle cdb bypass
    rs_slot_t [`RS_WAYS-1:0]            in_slot;
    // valid ways squeezed toward way 0
    rs_slot_t [`RS_WAYS-1:0]            packed_slot;
    logic [way_cw-1:0]                  valid_count;
    logic [way_cw-1:0]                  alloc_count;
    logic [`RS_WAYS-1:0][`RS_DEPTH-1:0] pick;
    logic                               transfer;

    // population count of free flags, no lag
    always_comb begin
        free_count = '0;
        for (int e = 0; e < `RS_DEPTH; e++) begin
            free_count = free_count + cnt_w'(bank.free[e]);
        end
    end

    // all or nothing, so room for a full group is needed
    assign dispatch_ready = free_count >= cnt_w'(`RS_WAYS);
    assign transfer       = dispatch_ready && |dispatch_valid;

    // build slots and catch tags broadcast this cycle
    always_comb begin
        for (int w = 0; w < `RS_WAYS; w++) begin
            raw_slot[w].opa       = dispatch_opa[w];
            raw_slot[w].opb       = dispatch_opb[w];
            raw_slot[w].opa_ready = dispatch_opa_ready[w];
            raw_slot[w].opb_ready = dispatch_opb_ready[w];
            raw_slot[w].dest      = dispatch_dest[w];
            raw_slot[w].rob       = dispatch_rob[w];
            raw_slot[w].op        = dispatch_op[w];
            in_slot[w] = slot_wakeup(raw_slot[w], cdb_valid, cdb_tag, cdb_data);
        end
    end

    // invalid ways drop out, order kept
    always_comb begin
        valid_count = '0;
        packed_slot = '0;
        for (int w = 0; w < `RS_WAYS; w++) begin
            if (dispatch_valid[w]) begin
                packed_slot[valid_count] = in_slot[w];
                valid_count              = valid_count + way_cw'(1);
            end
        end
    end

    assign alloc_count = transfer ? valid_count : '0;

    // kth valid way lands on kth lowest free entry
    rs_priority_pick #(
        .entries (`RS_DEPTH),
        .picks   (`RS_WAYS)
    ) i_free_pick (
        .request (bank.free),
        .count   (alloc_count),
        .pick    (pick),
        .picked  ()
    );

    always_comb begin
        bank.alloc      = '0;
        bank.alloc_slot = '0;
        for (int k = 0; k < `RS_WAYS; k++) begin
            for (int e = 0; e < `RS_DEPTH; e++) begin
                if (pick[k][e]) begin
                    bank.alloc[e]      = 1'b1;
                    bank.alloc_slot[e] = packed_slot[k];
                end
            end
        end
    end

endmodule

// File: hdl/rs_station_store.sv
// station entry registers
`timescale 1ns/1ps
`include "rs_settings.svh"

module rs_station_store
    import rs_pkg::*;
(
    input  logic                     clock,
    input  logic                     reset,

    input  logic [`RS_WAYS-1:0]      cdb_valid,
    input  prf_tag_t [`RS_WAYS-1:0]  cdb_tag,
    input  operand_t [`RS_WAYS-1:0]  cdb_data,

    rs_bank_if.store                 bank
);

    // one free flag per entry, the only control state
    logic [`RS_DEPTH-1:0]     free_q;
    // payload, meaningful only while occupied
    rs_slot_t [`RS_DEPTH-1:0] slot_q;
    // held slot after this cycle's cdb compare
    rs_slot_t [`RS_DEPTH-1:0] woken;

    always_comb begin
        for (int e = 0; e < `RS_DEPTH; e++) begin
            woken[e] = slot_wakeup(slot_q[e], cdb_valid, cdb_tag, cdb_data);
        end
    end

    // alloc hits free entries and grant hits occupied ones
    // so the two never meet on one entry
    always_ff @(posedge clock) begin
        if (reset) begin
            free_q <= '1;
        end else begin
            for (int e = 0; e < `RS_DEPTH; e++) begin
                if (bank.alloc[e]) begin
                    free_q[e] <= 1'b0;
                end else if (bank.grant[e]) begin
                    // counted free again from the next cycle
                    free_q[e] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int e = 0; e < `RS_DEPTH; e++) begin
            if (bank.alloc[e]) begin
                slot_q[e] <= bank.alloc_slot[e];
            end else if (!free_q[e]) begin
                // occupied, keep watching the cdb
                slot_q[e] <= woken[e];
            end
        end
    end

    assign bank.free = free_q;
    assign bank.held = slot_q;

    // eligible for issue once both operands are in
    always_comb begin
        for (int e = 0; e < `RS_DEPTH; e++) begin
            bank.ready[e] = !free_q[e] && slot_q[e].opa_ready && slot_q[e].opb_ready;
        end
    end

endmodule

// File: hdl/rs_issue_select.sv
// issue selection and packing
`timescale 1ns/1ps
`include "rs_settings.svh"

module rs_issue_select
    import rs_pkg::*;
(
    input  logic                     issue_ready,

    output logic [`RS_WAYS-1:0]      issue_valid,
    output operand_t [`RS_WAYS-1:0]  issue_opa,
    output operand_t [`RS_WAYS-1:0]  issue_opb,
    output prf_tag_t [`RS_WAYS-1:0]  issue_dest,
    output rob_idx_t [`RS_WAYS-1:0]  issue_rob,
    output rs_op_e [`RS_WAYS-1:0]    issue_op,

    rs_bank_if.issue                 bank
);

    localparam int way_cw = $clog2(`RS_WAYS + 1);
    // no cap beyond the way count on the issue side
    localparam logic [way_cw-1:0] all_ways = way_cw'(`RS_WAYS);

    logic [`RS_WAYS-1:0][`RS_DEPTH-1:0] pick;
    logic [way_cw-1:0]                  issue_count;
    rs_slot_t [`RS_WAYS-1:0]            out_slot;

    rs_priority_pick #(
        .entries (`RS_DEPTH),
        .picks   (`RS_WAYS)
    ) i_ready_pick (
        .request (bank.ready),
        .count   (all_ways),
        .pick    (pick),
        .picked  (issue_count)
    );

    // pick slots fill in order, so valid is a run from way 0
    always_comb begin
        for (int w = 0; w < `RS_WAYS; w++) begin
            issue_valid[w] = way_cw'(w) < issue_count;
        end
    end

    // one-hot mux per way, zero slot when unused
    always_comb begin
        out_slot = '0;
        for (int w = 0; w < `RS_WAYS; w++) begin
            for (int e = 0; e < `RS_DEPTH; e++) begin
                if (pick[w][e]) begin
                    out_slot[w] = bank.held[e];
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < `RS_WAYS; w++) begin
            issue_opa[w]  = out_slot[w].opa;
            issue_opb[w]  = out_slot[w].opb;
            issue_dest[w] = out_slot[w].dest;
            issue_rob[w]  = out_slot[w].rob;
            issue_op[w]   = out_slot[w].op;
        end
    end

    // entries leave only on a taken transfer
    always_comb begin
        bank.grant = '0;
        if (issue_ready) begin
            for (int w = 0; w < `RS_WAYS; w++) begin
                bank.grant = bank.grant | pick[w];
            end
        end
    end

endmodule

// File: hdl/rs_top.sv
// reservation station top
`timescale 1ns/1ps
`include "rs_settings.svh"

module rs_top
    import rs_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,

    // dispatch side, one lane per way
    input  logic [`RS_WAYS-1:0]         dispatch_valid,
    input  operand_t [`RS_WAYS-1:0]     dispatch_opa,
    input  operand_t [`RS_WAYS-1:0]     dispatch_opb,
    input  logic [`RS_WAYS-1:0]         dispatch_opa_ready,
    input  logic [`RS_WAYS-1:0]         dispatch_opb_ready,
    input  prf_tag_t [`RS_WAYS-1:0]     dispatch_dest,
    input  rob_idx_t [`RS_WAYS-1:0]     dispatch_rob,
    input  rs_op_e [`RS_WAYS-1:0]       dispatch_op,
    output logic                        dispatch_ready,

    // common data bus
    input  logic [`RS_WAYS-1:0]         cdb_valid,
    input  prf_tag_t [`RS_WAYS-1:0]     cdb_tag,
    input  operand_t [`RS_WAYS-1:0]     cdb_data,

    // issue side, packed from way 0
    input  logic                        issue_ready,
    output logic [`RS_WAYS-1:0]         issue_valid,
    output operand_t [`RS_WAYS-1:0]     issue_opa,
    output operand_t [`RS_WAYS-1:0]     issue_opb,
    output prf_tag_t [`RS_WAYS-1:0]     issue_dest,
    output rob_idx_t [`RS_WAYS-1:0]     issue_rob,
    output rs_op_e [`RS_WAYS-1:0]       issue_op,

    output logic [$clog2(`RS_DEPTH):0]  free_count
);

    rs_bank_if bank ();

    rs_dispatch_route i_dispatch_route (
        .dispatch_valid     (dispatch_valid),
        .dispatch_opa       (dispatch_opa),
        .dispatch_opb       (dispatch_opb),
        .dispatch_opa_ready (dispatch_opa_ready),
        .dispatch_opb_ready (dispatch_opb_ready),
        .dispatch_dest      (dispatch_dest),
        .dispatch_rob       (dispatch_rob),
        .dispatch_op        (dispatch_op),
        .cdb_valid          (cdb_valid),
        .cdb_tag            (cdb_tag),
        .cdb_data           (cdb_data),
        .dispatch_ready     (dispatch_ready),
        .free_count         (free_count),
        .bank               (bank.dispatch)
    );

    rs_station_store i_station_store (
        .clock     (clock),
        .reset     (reset),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_data  (cdb_data),
        .bank      (bank.store)
    );

    rs_issue_select i_issue_select (
        .issue_ready (issue_ready),
        .issue_valid (issue_valid),
        .issue_opa   (issue_opa),
        .issue_opb   (issue_opb),
        .issue_dest  (issue_dest),
        .issue_rob   (issue_rob),
        .issue_op    (issue_op),
        .bank        (bank.issue)
    );

endmodule

// File: bench/rs_tb_model.svh
// bench reference model
`ifndef RS_TB_MODEL_SVH
`define RS_TB_MODEL_SVH

// stimulus seed
int seed = 16813;

// outstanding instructions, indexed by rob
logic     sb_valid     [`RS_ROB];
operand_t sb_opa       [`RS_ROB];
operand_t sb_opb       [`RS_ROB];
logic     sb_opa_ready [`RS_ROB];
logic     sb_opb_ready [`RS_ROB];
prf_tag_t sb_dest      [`RS_ROB];
rs_op_e   sb_op        [`RS_ROB];
int       outstanding = 0;

// tags already on the cdb, and tags some operand waits for
logic     tag_sent    [`RS_PRF];
logic     tag_pending [`RS_PRF];

task automatic init_model();
    for (int r = 0; r < `RS_ROB; r++) begin
        sb_valid[r] = 1'b0;
    end
    for (int t = 0; t < `RS_PRF; t++) begin
        tag_sent[t]    = 1'b0;
        tag_pending[t] = 1'b0;
    end
    outstanding = 0;
endtask

function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
endfunction

// cdb data rule, one distinct value per tag
function automatic operand_t tag_value(input prf_tag_t tag);
    return 32'hcdb0_0000 + {26'd0, tag} * 32'h0001_0101;
endfunction

// value as dispatched, or the broadcast value of the tag in its low bits
function automatic operand_t expected_operand(input operand_t operand, input logic ready);
    if (ready) begin
        return operand;
    end
    return tag_value(operand[$bits(prf_tag_t)-1:0]);
endfunction

function automatic logic operand_available(input operand_t operand, input logic ready);
    return ready || tag_sent[operand[$bits(prf_tag_t)-1:0]];
endfunction

// random tag that has not been broadcast yet
function automatic prf_tag_t fresh_tag();
    prf_tag_t t;
    t = prf_tag_t'(rand_below(`RS_PRF));
    for (int i = 0; i < `RS_PRF && tag_sent[t]; i++) begin
        t = t + 1'b1;
    end
    return t;
endfunction

// random value, or a random unsent tag left waiting
function automatic operand_t make_operand(input int wait_pct, output logic ready);
    operand_t v;
    prf_tag_t t;
    v     = $random(seed);
    ready = rand_below(100) >= wait_pct;
    if (!ready) begin
        t = fresh_tag();
        v[$bits(prf_tag_t)-1:0] = t;
        tag_pending[t] = 1'b1;
    end
    return v;
endfunction

// rob index not outstanding and not used by this group
function automatic rob_idx_t free_rob(input logic [`RS_ROB-1:0] taken);
    int start;
    int r;
    start = rand_below(`RS_ROB);
    for (int i = 0; i < `RS_ROB; i++) begin
        r = (start + i) % `RS_ROB;
        if (!sb_valid[r] && !taken[r]) begin
            return rob_idx_t'(r);
        end
    end
    return rob_idx_t'(start);
endfunction

// accepted way goes into the scoreboard
task automatic record_way(input int w);
    rob_idx_t r;
    r = dispatch_rob[w];
    sb_valid[r]     = 1'b1;
    sb_opa[r]       = dispatch_opa[w];
    sb_opb[r]       = dispatch_opb[w];
    sb_opa_ready[r] = dispatch_opa_ready[w];
    sb_opb_ready[r] = dispatch_opb_ready[w];
    sb_dest[r]      = dispatch_dest[w];
    sb_op[r]        = dispatch_op[w];
    outstanding++;
endtask

`endif

// File: bench/rs_tb.sv
// reservation station testbench
`timescale 1ns/1ps
`include "rs_settings.svh"

module rs_tb
    import rs_pkg::*;
();

    logic                        clock;
    logic                        reset;
    logic [`RS_WAYS-1:0]         dispatch_valid;
    operand_t [`RS_WAYS-1:0]     dispatch_opa;
    operand_t [`RS_WAYS-1:0]     dispatch_opb;
    logic [`RS_WAYS-1:0]         dispatch_opa_ready;
    logic [`RS_WAYS-1:0]         dispatch_opb_ready;
    prf_tag_t [`RS_WAYS-1:0]     dispatch_dest;
    rob_idx_t [`RS_WAYS-1:0]     dispatch_rob;
    rs_op_e [`RS_WAYS-1:0]       dispatch_op;
    logic                        dispatch_ready;
    logic [`RS_WAYS-1:0]         cdb_valid;
    prf_tag_t [`RS_WAYS-1:0]     cdb_tag;
    operand_t [`RS_WAYS-1:0]     cdb_data;
    logic                        issue_ready;
    logic [`RS_WAYS-1:0]         issue_valid;
    operand_t [`RS_WAYS-1:0]     issue_opa;
    operand_t [`RS_WAYS-1:0]     issue_opb;
    prf_tag_t [`RS_WAYS-1:0]     issue_dest;
    rob_idx_t [`RS_WAYS-1:0]     issue_rob;
    rs_op_e [`RS_WAYS-1:0]       issue_op;
    logic [$clog2(`RS_DEPTH):0]  free_count;

    int check_errors = 0;
    int other_errors = 0;
    int issued       = 0;
    int guard;

    `include "rs_tb_model.svh"

    rs_top i_rs_top (.*);

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("CHECK FAILED time=%0t %s got=%h expected=%h", $time, name, got, expected);
        check_errors++;
    endtask

    task automatic fault(input string what);
        $display("ERROR at %0t: %s", $time, what);
        other_errors++;
    endtask

    // every taken issue way against the scoreboard, mid cycle
    always @(negedge clock) begin
        rob_idx_t r;
        logic     gap;
        if (!reset) begin
            gap = 1'b0;
            for (int w = 0; w < `RS_WAYS; w++) begin
                if (issue_valid[w] && gap) begin
                    fault("issue_valid bits not contiguous from way 0");
                end
                if (!issue_valid[w]) begin
                    gap = 1'b1;
                end
            end
            for (int w = 0; w < `RS_WAYS; w++) begin
                if (issue_valid[w] && issue_ready) begin
                    r = issue_rob[w];
                    if (!sb_valid[r]) begin
                        fault("issued a rob index that is not outstanding");
                    end else begin
                        if (!operand_available(sb_opa[r], sb_opa_ready[r]) ||
                            !operand_available(sb_opb[r], sb_opb_ready[r])) begin
                            fault("issued before its tag was broadcast");
                        end
                        if (issue_opa[w] !== expected_operand(sb_opa[r], sb_opa_ready[r])) begin
                            report_mismatch($sformatf("issue_opa[%0d]", w), issue_opa[w],
                                            expected_operand(sb_opa[r], sb_opa_ready[r]));
                        end
                        if (issue_opb[w] !== expected_operand(sb_opb[r], sb_opb_ready[r])) begin
                            report_mismatch($sformatf("issue_opb[%0d]", w), issue_opb[w],
                                            expected_operand(sb_opb[r], sb_opb_ready[r]));
                        end
                        if (issue_dest[w] !== sb_dest[r]) begin
                            report_mismatch($sformatf("issue_dest[%0d]", w), issue_dest[w],
                                            sb_dest[r]);
                        end
                        if (issue_op[w] !== sb_op[r]) begin
                            report_mismatch($sformatf("issue_op[%0d]", w), issue_op[w], sb_op[r]);
                        end
                        sb_valid[r] = 1'b0;
                        outstanding--;
                        issued++;
                    end
                end
            end
        end
    end

    // one group of up to three ways, bypass puts a waited tag on the cdb too
    task automatic send_group(input int wait_pct, input bit bypass);
        logic [`RS_WAYS-1:0] mask;
        logic [`RS_ROB-1:0]  taken;
        operand_t            va;
        operand_t            vb;
        logic                ra;
        logic                rb;
        rob_idx_t            rob;
        prf_tag_t            tag;
        int                  m;
        int                  wait_count;
        wait_count = 0;
        @(negedge clock);
        while (!dispatch_ready && wait_count < 100) begin
            @(negedge clock);
            wait_count++;
        end
        if (!dispatch_ready) begin
            fault("dispatch_ready stayed low");
            return;
        end
        m     = rand_below(7) + 1;
        mask  = m[`RS_WAYS-1:0];
        taken = '0;
        @(posedge clock);
        dispatch_valid <= mask;
        cdb_valid      <= '0;
        for (int w = 0; w < `RS_WAYS; w++) begin
            va  = make_operand(wait_pct, ra);
            vb  = make_operand(wait_pct, rb);
            rob = rob_idx_t'(rand_below(`RS_ROB));
            if (mask[w]) begin
                rob        = free_rob(taken);
                taken[rob] = 1'b1;
            end
            if (mask[w] && bypass) begin
                tag           = fresh_tag();
                tag_sent[tag] = 1'b1;
                if (rand_below(2) == 0) begin
                    va[$bits(prf_tag_t)-1:0] = tag;
                    ra = 1'b0;
                end else begin
                    vb[$bits(prf_tag_t)-1:0] = tag;
                    rb = 1'b0;
                end
                cdb_valid[w] <= 1'b1;
                cdb_tag[w]   <= tag;
                cdb_data[w]  <= tag_value(tag);
            end
            dispatch_opa[w]       <= va;
            dispatch_opb[w]       <= vb;
            dispatch_opa_ready[w] <= ra;
            dispatch_opb_ready[w] <= rb;
            dispatch_dest[w]      <= prf_tag_t'(rand_below(`RS_PRF));
            dispatch_rob[w]       <= rob;
            dispatch_op[w]        <= rs_op_e'(rand_below(3));
        end
        // free entries only grow meanwhile, so ready must still be high
        @(negedge clock);
        if (!dispatch_ready) begin
            fault("dispatch_ready fell while a group was offered");
        end
        for (int w = 0; w < `RS_WAYS; w++) begin
            if (dispatch_valid[w]) begin
                record_way(w);
            end
        end
        @(posedge clock);
        dispatch_valid <= '0;
        cdb_valid      <= '0;
    endtask

    // every waited tag not yet sent, three per cycle
    task automatic broadcast_pending();
        prf_tag_t q[$];
        for (int t = 0; t < `RS_PRF; t++) begin
            if (tag_pending[t] && !tag_sent[t]) begin
                q.push_back(prf_tag_t'(t));
            end
        end
        while (q.size() > 0) begin
            @(posedge clock);
            cdb_valid <= '0;
            for (int w = 0; w < `RS_WAYS; w++) begin
                if (q.size() > 0) begin
                    cdb_valid[w]   <= 1'b1;
                    cdb_tag[w]     <= q[0];
                    cdb_data[w]    <= tag_value(q[0]);
                    tag_sent[q[0]] = 1'b1;
                    void'(q.pop_front());
                end
            end
        end
        @(posedge clock);
        cdb_valid <= '0;
    endtask

    task automatic wait_drain();
        int wait_count;
        wait_count = 0;
        while (outstanding > 0 && wait_count < 500) begin
            @(negedge clock);
            wait_count++;
        end
        if (outstanding > 0) begin
            fault("outstanding instructions never issued");
        end
        @(negedge clock);
        if (free_count != `RS_DEPTH) begin
            report_mismatch("free_count", free_count, `RS_DEPTH);
        end
        // nothing waits any more, tags can be reused
        for (int t = 0; t < `RS_PRF; t++) begin
            tag_sent[t]    = 1'b0;
            tag_pending[t] = 1'b0;
        end
    endtask

    initial begin
        reset              = 1'b1;
        issue_ready        = 1'b1;
        dispatch_valid     = '0;
        dispatch_opa       = '0;
        dispatch_opb       = '0;
        dispatch_opa_ready = '0;
        dispatch_opb_ready = '0;
        dispatch_dest      = '0;
        dispatch_rob       = '0;
        for (int w = 0; w < `RS_WAYS; w++) begin
            dispatch_op[w] = op_alu;
        end
        cdb_valid = '0;
        cdb_tag   = '0;
        cdb_data  = '0;
        init_model();
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        // state straight after reset
        @(negedge clock);
        if (issue_valid !== '0) begin
            report_mismatch("issue_valid", issue_valid, 0);
        end
        if (free_count !== `RS_DEPTH) begin
            report_mismatch("free_count", free_count, `RS_DEPTH);
        end
        if (dispatch_ready !== 1'b1) begin
            report_mismatch("dispatch_ready", dispatch_ready, 1);
        end

        // all operands ready
        repeat (8) send_group(0, 1'b0);
        wait_drain();

        // waiting operands, idle a while before the broadcast
        repeat (4) send_group(60, 1'b0);
        repeat (10) @(negedge clock);
        broadcast_pending();
        wait_drain();

        // tag on the cdb in the dispatch cycle itself
        repeat (4) send_group(0, 1'b1);
        wait_drain();

        // fill with issue held off
        @(posedge clock);
        issue_ready <= 1'b0;
        guard = 0;
        @(negedge clock);
        while (dispatch_ready && guard < 20) begin
            send_group(20, 1'b0);
            @(negedge clock);
            if (free_count != `RS_DEPTH - outstanding) begin
                report_mismatch("free_count", free_count, `RS_DEPTH - outstanding);
            end
            if (dispatch_ready !== ((`RS_DEPTH - outstanding) >= `RS_WAYS)) begin
                report_mismatch("dispatch_ready", dispatch_ready,
                                (`RS_DEPTH - outstanding) >= `RS_WAYS);
            end
            guard++;
        end
        if (dispatch_ready) begin
            fault("station never filled under back-pressure");
        end
        // held entries still capture while stalled
        broadcast_pending();
        issue_ready <= 1'b1;
        wait_drain();

        // random mix of waits, bypass and back-pressure
        @(posedge clock);
        repeat (12) begin
            if (outstanding > 8) begin
                issue_ready <= 1'b1;
                broadcast_pending();
            end else begin
                issue_ready <= rand_below(4) != 0;
            end
            send_group(25, rand_below(4) == 0);
        end
        issue_ready <= 1'b1;
        broadcast_pending();
        wait_drain();

        repeat (2) @(negedge clock);
        $display("issued %0d, check errors %0d, other errors %0d",
                 issued, check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+hdl
+incdir+bench
hdl/rs_pkg.sv
hdl/rs_bank_if.sv
hdl/rs_priority_pick.sv
hdl/rs_dispatch_route.sv
hdl/rs_station_store.sv
hdl/rs_issue_select.sv
hdl/rs_top.sv
bench/rs_tb.sv

// File: Makefile
TOP = rs_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -Wno-fatal -f tb.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
